// ==== verilog/phv_pkg.sv ====
// phv layout: header vector, container, key, offset entry and comparator opcode types
`default_nettype none

package phv_pkg;

    localparam int PHV_LEN    = 1124;
    localparam int NUM_CONT   = 8;
    localparam int NUM_STAGES = 5;

    typedef logic [PHV_LEN-1:0] phv_t;

    typedef logic [47:0] cont6_t;
    typedef logic [31:0] cont4_t;
    typedef logic [15:0] cont2_t;
    typedef logic [2:0]  cont_idx_t;

    // table index, upper nibble of the vlan id low byte
    typedef logic [3:0] tenant_t;
    localparam int TENANT_LSB = 133;

    // container groups from the top down, index 7 highest within each group
    localparam int CONT6_TOP = PHV_LEN - 1;
    localparam int CONT4_TOP = CONT6_TOP - NUM_CONT * $bits(cont6_t);
    localparam int CONT2_TOP = CONT4_TOP - NUM_CONT * $bits(cont4_t);

    // opcode of stage 0 starts at bit 355, each later stage 20 bits lower
    localparam int CMP_OP_TOP = CONT2_TOP - NUM_CONT * $bits(cont2_t);

    // two fields per container size, then one comparator bit per stage
    localparam int KEY_LEN = 2 * ($bits(cont6_t) + $bits(cont4_t) + $bits(cont2_t))
                             + NUM_STAGES;

    typedef logic [KEY_LEN-1:0] key_t;

    // key field order, most significant first
    typedef struct packed {
        cont_idx_t c6_hi;
        cont_idx_t c6_lo;
        cont_idx_t c4_hi;
        cont_idx_t c4_lo;
        cont_idx_t c2_hi;
        cont_idx_t c2_lo;
    } offset_entry_t;

    typedef enum logic [1:0] {
        CMP_GT     = 2'b00,
        CMP_GE     = 2'b01,
        CMP_EQ     = 2'b10,
        CMP_ALWAYS = 2'b11
    } cmp_kind_t;

    // class 2'b11 has no container behind it
    typedef enum logic [1:0] {
        CLS_2B = 2'b00,
        CLS_4B = 2'b01,
        CLS_6B = 2'b10
    } cont_class_t;

    // immediate byte when imm is set, otherwise val[4:3] class and val[2:0] index
    typedef struct packed {
        logic       imm;
        logic [7:0] val;
    } cmp_opnd_t;

    typedef struct packed {
        cmp_kind_t kind;
        cmp_opnd_t opnd_a;
        cmp_opnd_t opnd_b;
    } cmp_op_t;

endpackage

`default_nettype wire

// ==== verilog/ctrl_pkg.sv ====
// control stream: beat type, header field positions and match constants
`default_nettype none

package ctrl_pkg;

    localparam int CTRL_WIDTH = 512;

    typedef logic [CTRL_WIDTH-1:0] ctrl_data_t;

    // header fields as they sit on the little-endian bus
    localparam int MOD_ID_LSB = 368;
    localparam int MOD_ID_W   = 8;

    // low module id bits carry the extractor id, the rest the stage
    localparam int EX_ID_W = 3;

    // zero selects the offset table, any other value the mask table
    localparam int RESV_LSB = 380;
    localparam int RESV_W   = 4;

    localparam int FLAG_LSB = 320;
    localparam int FLAG_W   = 16;

    localparam int INDEX_LSB = 384;
    localparam int INDEX_W   = 8;

    localparam logic [FLAG_W-1:0] CTRL_FLAG = 16'hf1f2;

endpackage

`default_nettype wire

// ==== verilog/table_wr_if.sv ====
// table write bus between the control parser and the key builder
`timescale 1ns/100ps
`default_nettype none

interface table_wr_if;

    // one-cycle strobes, never both high
    logic                 off_wr;
    logic                 mask_wr;
    phv_pkg::tenant_t     index;
    // beat already in big-endian byte order
    ctrl_pkg::ctrl_data_t data;

    modport parser (
        output off_wr,
        output mask_wr,
        output index,
        output data
    );

    modport builder (
        input off_wr,
        input mask_wr,
        input index,
        input data
    );

endinterface

`default_nettype wire

// ==== verilog/key_table.sv ====
// per-tenant table: one write port, one registered read port, typed by its entry
`timescale 1ns/100ps
`default_nettype none

module key_table #(
    parameter type entry_t = logic [7:0]
) (
    input  wire                   clk,
    input  wire                   wr_en,
    input  wire phv_pkg::tenant_t wr_addr,
    input  wire entry_t           wr_data,
    input  wire phv_pkg::tenant_t rd_addr,
    output entry_t                rd_data
);

    localparam int DEPTH = 2 ** $bits(phv_pkg::tenant_t);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // a write to the address being read shows up on the next read
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/ctrl_parser.sv ====
// control parser: claims table write packets for this extractor, forwards other beats
`timescale 1ns/100ps
`default_nettype none

module ctrl_parser #(
    parameter int unsigned STAGE_ID  = 0,
    parameter int unsigned KEY_EX_ID = 1
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire ctrl_pkg::ctrl_data_t s_tdata,
    input  wire                       s_tvalid,
    input  wire                       s_tlast,
    output ctrl_pkg::ctrl_data_t      m_tdata,
    output logic                      m_tvalid,
    output logic                      m_tlast,
    table_wr_if.parser                wr
);

    localparam int STAGE_W   = ctrl_pkg::MOD_ID_W - ctrl_pkg::EX_ID_W;
    localparam int TENANT_W  = $bits(phv_pkg::tenant_t);
    localparam int NUM_BYTES = ctrl_pkg::CTRL_WIDTH / 8;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_OFF,
        ST_WR_MASK
    } state_t;

    state_t                           state;
    phv_pkg::tenant_t                 idx_q;
    logic [ctrl_pkg::MOD_ID_W-1:0]    mod_id;
    logic [ctrl_pkg::RESV_W-1:0]      resv;
    logic [ctrl_pkg::FLAG_W-1:0]      flag;
    logic [ctrl_pkg::INDEX_W-1:0]     start_idx;
    logic                             stage_hit;
    logic                             ex_hit;
    logic                             claim;
    ctrl_pkg::ctrl_data_t             swapped;

    assign mod_id    = s_tdata[ctrl_pkg::MOD_ID_LSB +: ctrl_pkg::MOD_ID_W];
    assign resv      = s_tdata[ctrl_pkg::RESV_LSB +: ctrl_pkg::RESV_W];
    assign flag      = s_tdata[ctrl_pkg::FLAG_LSB +: ctrl_pkg::FLAG_W];
    assign start_idx = s_tdata[ctrl_pkg::INDEX_LSB +: ctrl_pkg::INDEX_W];

    assign stage_hit = mod_id[ctrl_pkg::MOD_ID_W-1 -: STAGE_W] == STAGE_W'(STAGE_ID);
    assign ex_hit    = mod_id[ctrl_pkg::EX_ID_W-1:0] == ctrl_pkg::EX_ID_W'(KEY_EX_ID);

    // only a packet header seen in idle can be claimed
    assign claim = (state == ST_IDLE) && s_tvalid && stage_hit && ex_hit
                   && (flag == ctrl_pkg::CTRL_FLAG);

    // byte 0 of the bus ends up as the top byte of the table word
    for (genvar b = 0; b < NUM_BYTES; b++) begin : g_swap
        assign swapped[b*8 +: 8] = s_tdata[ctrl_pkg::CTRL_WIDTH-8-b*8 +: 8];
    end

    // writes land at the edge that carries the beat
    assign wr.off_wr  = (state == ST_WR_OFF) && s_tvalid;
    assign wr.mask_wr = (state == ST_WR_MASK) && s_tvalid;
    assign wr.index   = idx_q;
    assign wr.data    = swapped;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            idx_q    <= '0;
            m_tdata  <= '0;
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (claim) begin
                        // header beat is swallowed, data beats follow
                        idx_q    <= start_idx[TENANT_W-1:0];
                        m_tvalid <= 1'b0;
                        m_tlast  <= 1'b0;
                        if (!s_tlast) begin
                            state <= (resv == '0) ? ST_WR_OFF : ST_WR_MASK;
                        end
                    end else begin
                        m_tdata  <= s_tdata;
                        m_tvalid <= s_tvalid;
                        m_tlast  <= s_tlast;
                    end
                end
                default: begin
                    // both write states consume every beat up to tlast
                    m_tvalid <= 1'b0;
                    m_tlast  <= 1'b0;
                    if (s_tvalid) begin
                        idx_q <= idx_q + 1'b1;
                        if (s_tlast) begin
                            state <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/key_builder.sv ====
// key builder: container capture, comparator, key and mask assembly, aligned phv output
`timescale 1ns/100ps
`default_nettype none

module key_builder #(
    parameter int unsigned STAGE_ID = 0
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire phv_pkg::phv_t phv_in,
    input  wire                phv_valid_in,
    table_wr_if.builder        wr,
    output phv_pkg::phv_t      phv_out,
    output logic               phv_valid_out,
    output phv_pkg::key_t      key_out,
    output logic               key_valid_out,
    output phv_pkg::key_t      key_mask_out
);

    localparam int W6      = $bits(phv_pkg::cont6_t);
    localparam int W4      = $bits(phv_pkg::cont4_t);
    localparam int W2      = $bits(phv_pkg::cont2_t);
    localparam int OP_W    = $bits(phv_pkg::cmp_op_t);
    localparam int OP_TOP  = phv_pkg::CMP_OP_TOP - OP_W * STAGE_ID;
    localparam int CMP_BIT = phv_pkg::NUM_STAGES - 1 - STAGE_ID;

    phv_pkg::cont6_t                 cont6_q [phv_pkg::NUM_CONT];
    phv_pkg::cont4_t                 cont4_q [phv_pkg::NUM_CONT];
    phv_pkg::cont2_t                 cont2_q [phv_pkg::NUM_CONT];
    phv_pkg::cmp_op_t                op_q;
    phv_pkg::phv_t                   phv_d1;
    logic                            valid_d1;

    phv_pkg::tenant_t                tenant;
    phv_pkg::offset_entry_t          off_wr_data;
    phv_pkg::offset_entry_t          off_entry;
    phv_pkg::key_t                   mask_wr_data;
    phv_pkg::key_t                   mask_entry;

    logic [7:0]                      opnd_a;
    logic [7:0]                      opnd_b;
    logic                            cmp_bit;
    logic [phv_pkg::NUM_STAGES-1:0]  cmp_bits;
    phv_pkg::key_t                   key_next;

    // operand byte from an immediate or the low byte of a captured container
    function automatic logic [7:0] operand_sel(input phv_pkg::cmp_opnd_t opnd);
        phv_pkg::cont_idx_t idx;
        logic [7:0]         val;
        idx = opnd.val[2:0];
        if (opnd.imm) begin
            val = opnd.val;
        end else begin
            case (opnd.val[4:3])
                phv_pkg::CLS_6B: val = cont6_q[idx][7:0];
                phv_pkg::CLS_4B: val = cont4_q[idx][7:0];
                phv_pkg::CLS_2B: val = cont2_q[idx][7:0];
                default:         val = 8'h00;
            endcase
        end
        return val;
    endfunction

    // tables are read with the same edge that captures the containers
    assign tenant       = phv_in[phv_pkg::TENANT_LSB +: $bits(phv_pkg::tenant_t)];
    assign off_wr_data  = wr.data[ctrl_pkg::CTRL_WIDTH-1 -: $bits(phv_pkg::offset_entry_t)];
    assign mask_wr_data = wr.data[ctrl_pkg::CTRL_WIDTH-1 -: phv_pkg::KEY_LEN];

    key_table #(
        .entry_t (phv_pkg::offset_entry_t)
    ) off_table (
        .clk     (clk),
        .wr_en   (wr.off_wr),
        .wr_addr (wr.index),
        .wr_data (off_wr_data),
        .rd_addr (tenant),
        .rd_data (off_entry)
    );

    key_table #(
        .entry_t (phv_pkg::key_t)
    ) mask_table (
        .clk     (clk),
        .wr_en   (wr.mask_wr),
        .wr_addr (wr.index),
        .wr_data (mask_wr_data),
        .rd_addr (tenant),
        .rd_data (mask_entry)
    );

    // edge 1: containers, this stage's opcode and the phv itself
    always_ff @(posedge clk) begin
        for (int k = 0; k < phv_pkg::NUM_CONT; k++) begin
            cont6_q[k] <= phv_in[phv_pkg::CONT4_TOP + 1 + k * W6 +: W6];
            cont4_q[k] <= phv_in[phv_pkg::CONT2_TOP + 1 + k * W4 +: W4];
            cont2_q[k] <= phv_in[phv_pkg::CMP_OP_TOP + 1 + k * W2 +: W2];
        end
        op_q   <= phv_in[OP_TOP -: OP_W];
        phv_d1 <= phv_in;
    end

    always_comb begin
        opnd_a  = operand_sel(op_q.opnd_a);
        opnd_b  = operand_sel(op_q.opnd_b);
        cmp_bit = 1'b0;
        case (op_q.kind)
            phv_pkg::CMP_GT:     cmp_bit = opnd_a > opnd_b;
            phv_pkg::CMP_GE:     cmp_bit = opnd_a >= opnd_b;
            phv_pkg::CMP_EQ:     cmp_bit = opnd_a == opnd_b;
            phv_pkg::CMP_ALWAYS: cmp_bit = 1'b1;
        endcase
        // other stages' comparator bits stay clear
        cmp_bits          = '0;
        cmp_bits[CMP_BIT] = cmp_bit;
        key_next = {cont6_q[off_entry.c6_hi], cont6_q[off_entry.c6_lo],
                    cont4_q[off_entry.c4_hi], cont4_q[off_entry.c4_lo],
                    cont2_q[off_entry.c2_hi], cont2_q[off_entry.c2_lo],
                    cmp_bits};
    end

    // edge 2: outputs, key and mask hold between valid phvs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d1      <= 1'b0;
            phv_out       <= '0;
            phv_valid_out <= 1'b0;
            key_out       <= '0;
            key_valid_out <= 1'b0;
            key_mask_out  <= '0;
        end else begin
            valid_d1      <= phv_valid_in;
            phv_out       <= phv_d1;
            phv_valid_out <= valid_d1;
            key_valid_out <= valid_d1;
            if (valid_d1) begin
                key_out      <= key_next;
                key_mask_out <= mask_entry;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/key_extract.sv ====
// key extractor top: control parser and key builder joined by the table write bus
`timescale 1ns/100ps
`default_nettype none

module key_extract #(
    parameter int unsigned STAGE_ID  = 0,
    parameter int unsigned KEY_EX_ID = 1
) (
    input  wire                       clk,
    input  wire                       rst_n,

    // data plane
    input  wire phv_pkg::phv_t        phv_in,
    input  wire                       phv_valid_in,
    output phv_pkg::phv_t             phv_out,
    output logic                      phv_valid_out,
    output phv_pkg::key_t             key_out,
    output logic                      key_valid_out,
    output phv_pkg::key_t             key_mask_out,

    // control stream
    input  wire ctrl_pkg::ctrl_data_t c_s_tdata,
    input  wire                       c_s_tvalid,
    input  wire                       c_s_tlast,
    output ctrl_pkg::ctrl_data_t      c_m_tdata,
    output logic                      c_m_tvalid,
    output logic                      c_m_tlast
);

    table_wr_if wr_bus ();

    ctrl_parser #(
        .STAGE_ID  (STAGE_ID),
        .KEY_EX_ID (KEY_EX_ID)
    ) u_parser (
        .clk      (clk),
        .rst_n    (rst_n),
        .s_tdata  (c_s_tdata),
        .s_tvalid (c_s_tvalid),
        .s_tlast  (c_s_tlast),
        .m_tdata  (c_m_tdata),
        .m_tvalid (c_m_tvalid),
        .m_tlast  (c_m_tlast),
        .wr       (wr_bus.parser)
    );

    key_builder #(
        .STAGE_ID (STAGE_ID)
    ) u_builder (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .wr            (wr_bus.builder),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

`default_nettype wire

// ==== dv/key_extract_tb.sv ====
// clock, reset, case reader, reference model, compare tasks and watchdog for the key extractor
`timescale 1ns/100ps
`default_nettype none

module key_extract_tb;

    localparam int unsigned STAGE_ID   = 2;
    localparam int unsigned KEY_EX_ID  = 1;
    localparam int          CLK_PERIOD = 10;
    localparam int          RST_CYCLES = 16;
    // low ends of the container groups and the stage 2 opcode top bit
    localparam int          C6_LSB     = 740;
    localparam int          C4_LSB     = 484;
    localparam int          C2_LSB     = 356;
    localparam int          OP_MSB     = 315;
    localparam logic [7:0]  OWN_MOD_ID = 8'h11;

    logic                 clk;
    logic                 rst_n;
    phv_pkg::phv_t        phv_in;
    logic                 phv_valid_in;
    ctrl_pkg::ctrl_data_t c_s_tdata;
    logic                 c_s_tvalid;
    logic                 c_s_tlast;
    phv_pkg::phv_t        phv_out;
    logic                 phv_valid_out;
    phv_pkg::key_t        key_out;
    logic                 key_valid_out;
    phv_pkg::key_t        key_mask_out;
    ctrl_pkg::ctrl_data_t c_m_tdata;
    logic                 c_m_tvalid;
    logic                 c_m_tlast;

    int seed = 26;
    int cycle = 0;
    int errors = 0;
    int nchecks = 0;
    logic checking = 1'b0;
    logic loaded = 1'b0;

    // case list as read from the file
    logic [7:0]   kind_q [$];
    logic [255:0] fa_q [$];
    logic [255:0] fb_q [$];
    logic [255:0] fc_q [$];
    logic [255:0] fd_q [$];
    logic [255:0] fe_q [$];

    // reference copies of both tables
    logic [17:0]   off_model [16];
    phv_pkg::key_t mask_model [16];

    // outstanding data-plane and control results
    phv_pkg::phv_t        exp_phv_q [$];
    phv_pkg::key_t        exp_key_q [$];
    phv_pkg::key_t        exp_mask_q [$];
    int                   exp_due_q [$];
    int                   exp_case_q [$];
    ctrl_pkg::ctrl_data_t ctl_data_q [$];
    logic                 ctl_last_q [$];
    int                   ctl_due_q [$];
    int                   ctl_case_q [$];

    key_extract #(
        .STAGE_ID  (STAGE_ID),
        .KEY_EX_ID (KEY_EX_ID)
    ) dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out),
        .c_s_tdata     (c_s_tdata),
        .c_s_tvalid    (c_s_tvalid),
        .c_s_tlast     (c_s_tlast),
        .c_m_tdata     (c_m_tdata),
        .c_m_tvalid    (c_m_tvalid),
        .c_m_tlast     (c_m_tlast)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_key(input phv_pkg::key_t got, input phv_pkg::key_t exp, input int cno);
        nchecks++;
        if (got !== exp) begin
            $display("mismatch at %0t: case %0d key_out %h, expected %h", $time, cno, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input phv_pkg::key_t got, input phv_pkg::key_t exp, input int cno);
        nchecks++;
        if (got !== exp) begin
            $display("mismatch at %0t: case %0d key_mask_out %h, expected %h",
                     $time, cno, got, exp);
            errors++;
        end
    endtask

    task automatic check_phv(input phv_pkg::phv_t got, input phv_pkg::phv_t exp, input int cno);
        nchecks++;
        if (got !== exp) begin
            $display("mismatch at %0t: case %0d phv_out differs from the PHV sent", $time, cno);
            errors++;
        end
    endtask

    task automatic check_ctrl(input ctrl_pkg::ctrl_data_t got, input ctrl_pkg::ctrl_data_t exp,
                              input int cno);
        nchecks++;
        if (got !== exp) begin
            $display("mismatch at %0t: case %0d c_m_tdata %h, expected %h", $time, cno, got, exp);
            errors++;
        end
    endtask

    task automatic report_case(input int cno, input string what, input int errs_before);
        if (errors == errs_before) begin
            $display("case %0d (%s): pass", cno, what);
        end else begin
            $display("case %0d (%s): fail", cno, what);
        end
    endtask

    // byte 0 of the bus carries the top byte of the table word
    function automatic ctrl_pkg::ctrl_data_t byte_reverse(input ctrl_pkg::ctrl_data_t w);
        ctrl_pkg::ctrl_data_t r;
        for (int b = 0; b < 64; b++) begin
            r[b*8 +: 8] = w[504 - b*8 +: 8];
        end
        return r;
    endfunction

    function automatic logic [47:0] cont6(input phv_pkg::phv_t p, input logic [2:0] i);
        return p[C6_LSB + 48 * int'(i) +: 48];
    endfunction

    function automatic logic [31:0] cont4(input phv_pkg::phv_t p, input logic [2:0] i);
        return p[C4_LSB + 32 * int'(i) +: 32];
    endfunction

    function automatic logic [15:0] cont2(input phv_pkg::phv_t p, input logic [2:0] i);
        return p[C2_LSB + 16 * int'(i) +: 16];
    endfunction

    // a container operand reads the low byte of its container and class 11 reads none
    function automatic phv_pkg::phv_t force_operand(input phv_pkg::phv_t p,
                                                     input logic [8:0] opnd,
                                                     input logic [7:0] b);
        phv_pkg::phv_t r;
        int            idx;
        r = p;
        idx = int'(opnd[2:0]);
        if (!opnd[8]) begin
            case (opnd[4:3])
                2'b10: r[C6_LSB + 48 * idx +: 8] = b;
                2'b01: r[C4_LSB + 32 * idx +: 8] = b;
                2'b00: r[C2_LSB + 16 * idx +: 8] = b;
                default: r = p;
            endcase
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        phv_valid_in = 1'b0;
        c_s_tvalid   = 1'b0;
        c_s_tlast    = 1'b0;
    endtask

    // header beat followed by one or two table words
    task automatic send_table_write(input logic [3:0] resv, input phv_pkg::tenant_t start,
                                    input int beats, input ctrl_pkg::ctrl_data_t w0,
                                    input ctrl_pkg::ctrl_data_t w1);
        ctrl_pkg::ctrl_data_t hdr;
        hdr = '0;
        hdr[ctrl_pkg::MOD_ID_LSB +: 8] = OWN_MOD_ID;
        hdr[ctrl_pkg::RESV_LSB +: 4]   = resv;
        hdr[ctrl_pkg::FLAG_LSB +: 16]  = ctrl_pkg::CTRL_FLAG;
        hdr[ctrl_pkg::INDEX_LSB +: 8]  = {4'h0, start};
        next_cycle();
        c_s_tdata  = hdr;
        c_s_tvalid = 1'b1;
        next_cycle();
        c_s_tdata  = byte_reverse(w0);
        c_s_tvalid = 1'b1;
        c_s_tlast  = (beats == 1);
        if (beats > 1) begin
            next_cycle();
            c_s_tdata  = byte_reverse(w1);
            c_s_tvalid = 1'b1;
            c_s_tlast  = 1'b1;
        end
    endtask

    task automatic send_phv(input int cno, input phv_pkg::tenant_t t, input logic [19:0] op,
                            input logic exp_bit, input logic [7:0] ba, input logic [7:0] bb);
        logic [1151:0] raw;
        phv_pkg::phv_t p;
        phv_pkg::key_t k;
        logic [17:0]   e;
        for (int w = 0; w < 36; w++) begin
            raw[w*32 +: 32] = $random(seed);
        end
        p = raw[1123:0];
        p[phv_pkg::TENANT_LSB +: 4] = t;
        p[OP_MSB -: 20] = op;
        p = force_operand(p, op[17:9], ba);
        p = force_operand(p, op[8:0], bb);
        e = off_model[t];
        // stage 2 owns key bit 2 and the other comparator bits stay 0
        k = {cont6(p, e[17:15]), cont6(p, e[14:12]), cont4(p, e[11:9]), cont4(p, e[8:6]),
             cont2(p, e[5:3]), cont2(p, e[2:0]), 2'b00, exp_bit, 2'b00};
        next_cycle();
        phv_in       = p;
        phv_valid_in = 1'b1;
        exp_phv_q.push_back(p);
        exp_key_q.push_back(k);
        exp_mask_q.push_back(mask_model[t]);
        exp_due_q.push_back(cycle + 2);
        exp_case_q.push_back(cno);
    endtask

    task automatic send_foreign(input int cno, input logic [7:0] mod_id, input logic [15:0] flag);
        ctrl_pkg::ctrl_data_t beat;
        logic                 last;
        for (int w = 0; w < 16; w++) begin
            beat[w*32 +: 32] = $random(seed);
        end
        beat[ctrl_pkg::MOD_ID_LSB +: 8] = mod_id;
        beat[ctrl_pkg::FLAG_LSB +: 16]  = flag;
        last = ($random(seed) % 2) != 0;
        next_cycle();
        c_s_tdata  = beat;
        c_s_tvalid = 1'b1;
        c_s_tlast  = last;
        ctl_data_q.push_back(beat);
        ctl_last_q.push_back(last);
        ctl_due_q.push_back(cycle + 1);
        ctl_case_q.push_back(cno);
    endtask

    task automatic run_cases();
        ctrl_pkg::ctrl_data_t w0;
        ctrl_pkg::ctrl_data_t w1;
        phv_pkg::tenant_t     t;
        for (int i = 0; i < kind_q.size(); i++) begin
            t = fa_q[i][3:0];
            w0 = '0;
            w1 = '0;
            case (kind_q[i])
                "O": begin
                    w0[511 -: 18] = fc_q[i][17:0];
                    w1[511 -: 18] = fd_q[i][17:0];
                    send_table_write(4'h0, t, int'(fb_q[i][1:0]), w0, w1);
                    off_model[t] = fc_q[i][17:0];
                    if (fb_q[i][1:0] == 2'd2) begin
                        off_model[t + 4'd1] = fd_q[i][17:0];
                    end
                    $display("case %0d (offset write, tenant %0d): done", i, t);
                end
                "M": begin
                    w0[511 -: 197] = fb_q[i][196:0];
                    send_table_write(4'h1, t, 1, w0, w1);
                    mask_model[t] = fb_q[i][196:0];
                    $display("case %0d (mask write, tenant %0d): done", i, t);
                end
                "P": send_phv(i, t, fb_q[i][19:0], fc_q[i][0], fd_q[i][7:0], fe_q[i][7:0]);
                "F": send_foreign(i, fa_q[i][7:0], fb_q[i][15:0]);
                default: begin
                    $display("case %0d has an unknown kind", i);
                    errors++;
                end
            endcase
        end
        next_cycle();
        repeat (6) @(posedge clk);
    endtask

    // outputs are sampled at the falling edge half a cycle after they change
    always @(negedge clk) begin : monitor
        int errs_before;
        if (checking) begin
            if (key_valid_out !== phv_valid_out) begin
                $display("%0t: key_valid_out and phv_valid_out disagree", $time);
                errors++;
            end
            if (key_valid_out === 1'b1) begin
                if (exp_due_q.size() == 0) begin
                    $display("%0t: key_valid_out is high with no PHV outstanding", $time);
                    errors++;
                end else begin
                    errs_before = errors;
                    if (exp_due_q[0] != cycle) begin
                        $display("%0t: case %0d key came out at cycle %0d instead of %0d",
                                 $time, exp_case_q[0], cycle, exp_due_q[0]);
                        errors++;
                    end
                    check_key(key_out, exp_key_q[0], exp_case_q[0]);
                    check_mask(key_mask_out, exp_mask_q[0], exp_case_q[0]);
                    check_phv(phv_out, exp_phv_q[0], exp_case_q[0]);
                    report_case(exp_case_q[0], "phv", errs_before);
                    void'(exp_phv_q.pop_front());
                    void'(exp_key_q.pop_front());
                    void'(exp_mask_q.pop_front());
                    void'(exp_due_q.pop_front());
                    void'(exp_case_q.pop_front());
                end
            end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle) begin
                $display("%0t: case %0d key_valid_out never came", $time, exp_case_q[0]);
                errors++;
                void'(exp_phv_q.pop_front());
                void'(exp_key_q.pop_front());
                void'(exp_mask_q.pop_front());
                void'(exp_due_q.pop_front());
                void'(exp_case_q.pop_front());
            end
            if (c_m_tvalid === 1'b1) begin
                if (ctl_due_q.size() == 0 || ctl_due_q[0] != cycle) begin
                    $display("%0t: c_m_tvalid is high where no beat was due", $time);
                    errors++;
                end else begin
                    errs_before = errors;
                    check_ctrl(c_m_tdata, ctl_data_q[0], ctl_case_q[0]);
                    if (c_m_tlast !== ctl_last_q[0]) begin
                        $display("mismatch at %0t: case %0d c_m_tlast %b, expected %b", $time,
                                 ctl_case_q[0], c_m_tlast, ctl_last_q[0]);
                        errors++;
                    end
                    report_case(ctl_case_q[0], "passthrough", errs_before);
                    void'(ctl_data_q.pop_front());
                    void'(ctl_last_q.pop_front());
                    void'(ctl_due_q.pop_front());
                    void'(ctl_case_q.pop_front());
                end
            end else if (ctl_due_q.size() != 0 && ctl_due_q[0] <= cycle) begin
                $display("%0t: case %0d beat never reached c_m_tdata", $time, ctl_case_q[0]);
                errors++;
                void'(ctl_data_q.pop_front());
                void'(ctl_last_q.pop_front());
                void'(ctl_due_q.pop_front());
                void'(ctl_case_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = (kind_q.size() * 20 + RST_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        int           fd;
        int           r;
        string        line;
        logic [7:0]   kind;
        logic [255:0] fa;
        logic [255:0] fb;
        logic [255:0] fc;
        logic [255:0] fd_v;
        logic [255:0] fe;
        rst_n        = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        c_s_tdata    = '0;
        c_s_tvalid   = 1'b0;
        c_s_tlast    = 1'b0;
        fd = $fopen("dv/key_extract_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/key_extract_cases.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 1 && line.getc(0) != 8'h23) begin
                    fa = '0;
                    fb = '0;
                    fc = '0;
                    fd_v = '0;
                    fe = '0;
                    r = $sscanf(line, "%c %h %h %h %h %h", kind, fa, fb, fc, fd_v, fe);
                    kind_q.push_back(kind);
                    fa_q.push_back(fa);
                    fb_q.push_back(fb);
                    fc_q.push_back(fc);
                    fd_q.push_back(fd_v);
                    fe_q.push_back(fe);
                end
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (RST_CYCLES) @(posedge clk);
            #1;
            rst_n = 1'b1;
            @(negedge clk);
            if (phv_valid_out !== 1'b0 || key_valid_out !== 1'b0 || c_m_tvalid !== 1'b0) begin
                $display("mismatch at %0t: a valid output is not 0 after reset", $time);
                errors++;
            end else begin
                $display("reset: pass");
            end
            checking = 1'b1;
            run_cases();
            $display("cases %0d, checks %0d, errors %0d", kind_q.size(), nchecks, errors);
            if (errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/key_extract_cases.txt ====
# O tenant beats entry entry_next | M tenant mask | F module_id flag
# P tenant opcode expected_bit byte_a byte_b (all hex, bytes go to container operands)
O 3 1 0a2c5 00000
O 5 2 3ffff 12345
O a 2 05397 2b8d1
M 3 1ffffffffffff000000000000ffffffffffff000000001f
M 5 0000ffffffff0000ffff0000ffff00000000ffff0000fff
M 6 1f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f
M a 0123456789abcdef0123456789abcdef0123456789abcde
F 12 f1f2
P 3 2a130 1 00 00
P 5 26150 0 00 00
P 6 68140 1 00 00
P a 82777 1 77 00
P 3 81b12 0 13 00
P 5 00e10 1 91 90
F 19 f1f2
P 6 41402 0 20 21
P a e01ff 1 00 00
P 3 83100 1 00 00
F 11 f1f3
P 5 42c09 1 80 7f
P 6 009ff 0 ff 00
M 5 1ffffffffffffffffffffffffffffffffffffffffffffffff
O 6 1 1b6db 00000
P 5 68140 1 00 00
P 6 2a130 1 00 00
P 3 82777 1 77 00
F 10 f1f2
P a 26150 0 00 00

// ==== sources.f ====
verilog/phv_pkg.sv
verilog/ctrl_pkg.sv
verilog/table_wr_if.sv
verilog/key_table.sv
verilog/ctrl_parser.sv
verilog/key_builder.sv
verilog/key_extract.sv
dv/key_extract_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= key_extract_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)
